//--- build.f
+incdir+sim
source/net_shell_pkg.sv
source/net_slice_array.sv
source/mem_cmd_offset.sv
source/net_config_regs.sv
source/net_shell_top.sv
sim/net_shell_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the network shell testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module net_shell_tb \
    -f build.f --Mdir obj_dir -o net_shell_sim || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/net_shell_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qxF '>>> PASS' && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

//--- sim/net_shell_ref.svh
// ============================================================
// Network shell reference model
// Expected memory requests, status words and station
// addresses, with the queues the compare process drains
// ============================================================

`ifndef NET_SHELL_REF_SVH
`define NET_SHELL_REF_SVH

// Station IP and MAC as seen on the outputs
typedef struct packed {
    logic [IP_ADDR_BITS-1:0]  ip;
    logic [MAC_ADDR_BITS-1:0] mac;
} station_t;

// Expected outputs, each with the cycle it is due in
typedef struct packed {
    int unsigned due;
    mem_cmd_t    req;
} exp_req_t;

typedef struct packed {
    int unsigned due;
    mem_sts_t    sts;
} exp_sts_t;

typedef struct packed {
    int unsigned due;
    station_t    state;
} exp_station_t;

exp_req_t     req_q[$];
exp_sts_t     sts_q[$];
exp_station_t station_q[$];

// Base offset added to the address, carry out of bit 47 dropped
function automatic mem_cmd_t expect_mem_req(input mem_cmd_t c, input logic [ADDR_BITS-1:0] off);
    logic [ADDR_BITS:0] sum;
    mem_cmd_t           r;
    sum    = {1'b0, c.addr} + {1'b0, off};
    r      = c;
    r.addr = sum[ADDR_BITS-1:0];
    return r;
endfunction

// Status words come back untouched
function automatic mem_sts_t expect_status(input mem_sts_t s);
    return s;
endfunction

// IP sits in the low 32 bits of the word, MAC takes all 48
function automatic station_t expect_station(input station_t cur, input cfg_upd_t u);
    station_t n;
    n = cur;
    if (u.kind == CFG_IP) begin
        n.ip = u.payload.mac[IP_ADDR_BITS-1:0];
    end else begin
        n.mac = u.payload.mac;
    end
    return n;
endfunction

`endif

//--- sim/net_shell_tb.sv
// ============================================================
// Network shell testbench
// Checks memory relocation, status return and station
// configuration against a reference model
// ============================================================

`timescale 1ns/10ps

module net_shell_tb
    import net_shell_pkg::*;
();

    localparam int N_STAGES    = 2;
    localparam int N_CMDS      = 40;
    localparam int N_STS       = 30;
    localparam int N_CFG       = 12;
    // Reset, idle check, single command, then the three bursts
    localparam int STIM_CYCLES = 2 + 3 + 1 + N_CMDS + N_STS + N_CFG;
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 50;

    logic                     aclk;
    logic                     aresetn;
    logic                     cmd_valid;
    mem_cmd_t                 cmd;
    logic [ADDR_BITS-1:0]     ddr_offset;
    logic                     mem_req_valid;
    mem_cmd_t                 mem_req;
    logic                     sts_valid;
    mem_sts_t                 sts;
    logic                     stack_sts_valid;
    mem_sts_t                 stack_sts;
    logic                     cfg_valid;
    cfg_upd_t                 cfg;
    logic [IP_ADDR_BITS-1:0]  ip_addr;
    logic [MAC_ADDR_BITS-1:0] mac_addr;

    `include "net_shell_ref.svh"

    integer      seed;
    int unsigned cyc = 0;
    int          check_errors = 0;
    int          flow_errors;
    int          tests_failed;
    int          errors_at_start;
    station_t    model_station;
    station_t    seen_station = '0;

    net_shell_top #(.N_STAGES(N_STAGES)) DUT (.*);

    always #10 aclk = ~aclk;

    // Cycle count for due times and the run limit
    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Outputs sampled mid-cycle, away from the clock edge
    always @(negedge aclk) begin
        if (aresetn) begin
            if (mem_req_valid) begin
                if (req_q.size() == 0) begin
                    $display("Error at %0t: memory request with no command outstanding", $time);
                    check_errors++;
                end else begin
                    if (req_q[0].due != cyc || mem_req !== req_q[0].req) begin
                        $display("Mismatch at %0t: request %h in cycle %0d, expected %h in %0d",
                                 $time, mem_req, cyc, req_q[0].req, req_q[0].due);
                        check_errors++;
                    end
                    void'(req_q.pop_front());
                end
            end else if (req_q.size() != 0 && req_q[0].due <= cyc) begin
                $display("Error at %0t: memory request due in cycle %0d never came",
                         $time, req_q[0].due);
                check_errors++;
                void'(req_q.pop_front());
            end
            if (stack_sts_valid) begin
                if (sts_q.size() == 0) begin
                    $display("Error at %0t: status strobe with no status outstanding", $time);
                    check_errors++;
                end else begin
                    if (sts_q[0].due != cyc || stack_sts !== sts_q[0].sts) begin
                        $display("Mismatch at %0t: status %h in cycle %0d, expected %h in %0d",
                                 $time, stack_sts, cyc, sts_q[0].sts, sts_q[0].due);
                        check_errors++;
                    end
                    void'(sts_q.pop_front());
                end
            end else if (sts_q.size() != 0 && sts_q[0].due <= cyc) begin
                $display("Error at %0t: status due in cycle %0d never came", $time, sts_q[0].due);
                check_errors++;
                void'(sts_q.pop_front());
            end
            // Station registers must hold between due cycles
            if (station_q.size() != 0 && station_q[0].due <= cyc) begin
                seen_station = station_q[0].state;
                void'(station_q.pop_front());
            end
            if (ip_addr !== seen_station.ip || mac_addr !== seen_station.mac) begin
                $display("Mismatch at %0t: ip %h mac %h, expected ip %h mac %h",
                         $time, ip_addr, mac_addr, seen_station.ip, seen_station.mac);
                check_errors++;
            end
        end
    end

    task automatic random_word(output logic [63:0] r);
        r = {$random(seed), $random(seed)};
    endtask

    // Random command with a non-zero length
    task automatic random_cmd(output mem_cmd_t c);
        logic [63:0] r;
        random_word(r);
        c.is_write = r[63];
        c.addr     = r[ADDR_BITS-1:0];
        c.len      = {13'd0, r[62:48]} + 28'd1;
    endtask

    task automatic drive_idle();
        @(posedge aclk);
        #1;
        cmd_valid = 1'b0;
        sts_valid = 1'b0;
        cfg_valid = 1'b0;
    endtask

    task automatic send_cmd(input mem_cmd_t c, input logic [ADDR_BITS-1:0] off);
        exp_req_t e;
        @(posedge aclk);
        #1;
        cmd_valid  = 1'b1;
        cmd        = c;
        ddr_offset = off;
        e.due      = cyc + N_STAGES + 1;
        e.req      = expect_mem_req(c, off);
        req_q.push_back(e);
    endtask

    task automatic send_sts(input logic v, input mem_sts_t s);
        exp_sts_t e;
        @(posedge aclk);
        #1;
        sts_valid = v;
        sts       = s;
        if (v) begin
            e.due = cyc + N_STAGES;
            e.sts = expect_status(s);
            sts_q.push_back(e);
        end
    endtask

    task automatic send_cfg(input cfg_upd_t u);
        exp_station_t e;
        @(posedge aclk);
        #1;
        cfg_valid     = 1'b1;
        cfg           = u;
        model_station = expect_station(model_station, u);
        e.due         = cyc + N_STAGES + 1;
        e.state       = model_station;
        station_q.push_back(e);
    endtask

    // Let the pipeline empty, then report the test
    task automatic finish_test(input int num, input string name);
        int errs;
        repeat (N_STAGES + 3) @(posedge aclk);
        if (req_q.size() != 0 || sts_q.size() != 0 || station_q.size() != 0) begin
            $display("Error: expected outputs still outstanding at the end of test %0d", num);
            flow_errors++;
        end
        errs = check_errors + flow_errors - errors_at_start;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d (%s): %s, %0d errors", num, name, (errs == 0) ? "ok" : "failed", errs);
        errors_at_start = check_errors + flow_errors;
    endtask

    initial begin
        mem_cmd_t             c;
        mem_sts_t             s;
        cfg_upd_t             u;
        logic [63:0]          r;
        logic [ADDR_BITS-1:0] off;

        seed            = 26;
        flow_errors     = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        model_station   = '0;
        aclk            = 1'b0;
        aresetn         = 1'b0;
        cmd_valid       = 1'b0;
        cmd             = '0;
        ddr_offset      = '0;
        sts_valid       = 1'b0;
        sts             = '0;
        cfg_valid       = 1'b0;
        cfg             = '0;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        repeat (3) begin
            @(negedge aclk);
            if (mem_req_valid !== 1'b0 || stack_sts_valid !== 1'b0 ||
                ip_addr !== '0 || mac_addr !== '0) begin
                $display("Error at %0t: outputs not quiet after reset", $time);
                flow_errors++;
            end
        end
        finish_test(1, "reset state");

        // Address wraps past 2^48
        c.is_write = 1'b1;
        c.addr     = 48'hffff_ffff_f000;
        c.len      = 28'd64;
        send_cmd(c, 48'h0000_0000_2000);
        drive_idle();
        finish_test(2, "single command");

        random_word(r);
        off = r[ADDR_BITS-1:0];
        for (int i = 0; i < N_CMDS; i++) begin
            random_word(r);
            if (r[1:0] == 2'b00) begin
                off = r[63:16];
            end
            random_cmd(c);
            send_cmd(c, off);
        end
        drive_idle();
        finish_test(3, "command burst");

        for (int i = 0; i < N_STS; i++) begin
            random_word(r);
            s = r[7:0];
            send_sts(r[8] | r[9], s);
        end
        drive_idle();
        finish_test(4, "status return");

        for (int i = 0; i < N_CFG; i++) begin
            random_word(r);
            // Open with one update of each kind
            u.kind = (i == 1 || (i > 1 && r[0])) ? CFG_MAC : CFG_IP;
            if (u.kind == CFG_IP) begin
                u.payload.mac = {16'h0000, r[47:16]};
            end else begin
                u.payload.mac = r[63:16];
            end
            send_cfg(u);
        end
        drive_idle();
        finish_test(5, "station config");

        $display("Summary: 5 tests run, %0d failed, %0d errors",
                 tests_failed, check_errors + flow_errors);
        if (tests_failed == 0 && check_errors + flow_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- source/net_shell_top.sv
// ============================================================
// Network shell top
// Slices the memory command, status and configuration paths
// and relocates memory commands by the base offset
// ============================================================

`timescale 1ns/10ps

module net_shell_top
    import net_shell_pkg::*;
#(
    parameter int N_STAGES = 2
) (
    input  logic                     aclk,
    input  logic                     aresetn,

    // Stack commands
    input  logic                     cmd_valid,
    input  mem_cmd_t                 cmd,
    input  logic [ADDR_BITS-1:0]     ddr_offset,

    // Toward memory
    output logic                     mem_req_valid,
    output mem_cmd_t                 mem_req,

    // Memory status
    input  logic                     sts_valid,
    input  mem_sts_t                 sts,
    output logic                     stack_sts_valid,
    output mem_sts_t                 stack_sts,

    // Configuration
    input  logic                     cfg_valid,
    input  cfg_upd_t                 cfg,
    output logic [IP_ADDR_BITS-1:0]  ip_addr,
    output logic [MAC_ADDR_BITS-1:0] mac_addr
);

    logic     cmd_slice_valid;
    mem_cmd_t cmd_slice;
    logic     cfg_slice_valid;
    cfg_upd_t cfg_slice;

    // Command path
    net_slice_array #(
        .N_STAGES  (N_STAGES),
        .DATA_BITS ($bits(mem_cmd_t))
    ) inst_cmd_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (cmd_valid),
        .in_data   (cmd),
        .out_valid (cmd_slice_valid),
        .out_data  (cmd_slice)
    );

    mem_cmd_offset #(
        .N_STAGES (N_STAGES)
    ) inst_cmd_offset (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ddr_offset (ddr_offset),
        .cmd_valid  (cmd_slice_valid),
        .cmd        (cmd_slice),
        .req_valid  (mem_req_valid),
        .req        (mem_req)
    );

    // Status path back to the stack
    net_slice_array #(
        .N_STAGES  (N_STAGES),
        .DATA_BITS ($bits(mem_sts_t))
    ) inst_sts_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (sts_valid),
        .in_data   (sts),
        .out_valid (stack_sts_valid),
        .out_data  (stack_sts)
    );

    // Configuration path
    net_slice_array #(
        .N_STAGES  (N_STAGES),
        .DATA_BITS ($bits(cfg_upd_t))
    ) inst_cfg_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (cfg_valid),
        .in_data   (cfg),
        .out_valid (cfg_slice_valid),
        .out_data  (cfg_slice)
    );

    net_config_regs inst_config_regs (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .upd_valid (cfg_slice_valid),
        .upd       (cfg_slice),
        .ip_addr   (ip_addr),
        .mac_addr  (mac_addr)
    );

endmodule

//--- source/net_config_regs.sv
// ============================================================
// Station configuration registers
// Decodes set-IP and set-MAC updates into the current
// station IP and MAC address
// ============================================================

`timescale 1ns/10ps

module net_config_regs
    import net_shell_pkg::*;
(
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     upd_valid,
    input  cfg_upd_t                 upd,
    output logic [IP_ADDR_BITS-1:0]  ip_addr,
    output logic [MAC_ADDR_BITS-1:0] mac_addr
);

    // One update loads one register, the other holds
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ip_addr  <= '0;
            mac_addr <= '0;
        end else if (upd_valid) begin
            case (upd.kind)
                CFG_IP:  ip_addr  <= upd.payload.ip_word.ip;
                CFG_MAC: mac_addr <= upd.payload.mac;
                default: ;
            endcase
        end
    end

    // IP updates carry a clean upper pad
    a_ip_pad: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (upd_valid && upd.kind == CFG_IP) |-> (upd.payload.ip_word.pad == '0)
    ) else $error("IP update with non-zero pad bits");

endmodule

//--- source/mem_cmd_offset.sv
// ============================================================
// Memory command relocation
// Delays the base offset to match the command slices, then
// adds it to each command address in one register stage
// ============================================================

`timescale 1ns/10ps

module mem_cmd_offset
    import net_shell_pkg::*;
#(
    parameter int N_STAGES = 2
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic [ADDR_BITS-1:0] ddr_offset,
    input  logic                 cmd_valid,
    input  mem_cmd_t             cmd,
    output logic                 req_valid,
    output mem_cmd_t             req
);

    // Offset delay line, same depth as the command slices
    logic [N_STAGES:0][ADDR_BITS-1:0] offset_q;

    assign offset_q[0] = ddr_offset;

    if (N_STAGES > 0) begin : g_offset_dly
        always_ff @(posedge aclk) begin
            for (int i = 1; i <= N_STAGES; i++) begin
                offset_q[i] <= offset_q[i-1];
            end
        end
    end

    // Request strobe
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= cmd_valid;
        end
    end

    // Relocated request, address wraps at 2^48
    always_ff @(posedge aclk) begin
        req.is_write <= cmd.is_write;
        req.addr     <= cmd.addr + offset_q[N_STAGES];
        req.len      <= cmd.len;
    end

    // Valid commands are never empty
    a_cmd_len: assert property (
        @(posedge aclk) disable iff (!aresetn)
        cmd_valid |-> (cmd.len != '0)
    ) else $error("memory command with zero length");

endmodule

//--- source/net_slice_array.sv
// ============================================================
// Register slice array
// Chain of valid-plus-payload register stages, no back-pressure
// ============================================================

`timescale 1ns/10ps

module net_slice_array #(
    parameter int N_STAGES  = 2,
    parameter int DATA_BITS = 8
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 in_valid,
    input  logic [DATA_BITS-1:0] in_data,
    output logic                 out_valid,
    output logic [DATA_BITS-1:0] out_data
);

    // Index 0 is the input, index N_STAGES the output
    logic [N_STAGES:0]                valid_q;
    logic [N_STAGES:0][DATA_BITS-1:0] data_q;

    assign valid_q[0] = in_valid;
    assign data_q[0]  = in_data;

    if (N_STAGES > 0) begin : g_regs
        // Strobe bits
        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                for (int i = 1; i <= N_STAGES; i++) begin
                    valid_q[i] <= 1'b0;
                end
            end else begin
                for (int i = 1; i <= N_STAGES; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        // Payload, meaningful only with its strobe
        always_ff @(posedge aclk) begin
            for (int i = 1; i <= N_STAGES; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[N_STAGES];
    assign out_data  = data_q[N_STAGES];

endmodule

//--- source/net_shell_pkg.sv
// ============================================================
// Network shell package
// Widths and channel types shared by the memory command,
// memory status and configuration paths of the shell
// ============================================================

package net_shell_pkg;

    // Address and length widths
    localparam int ADDR_BITS     = 48;
    localparam int LEN_BITS      = 28;
    localparam int IP_ADDR_BITS  = 32;
    localparam int MAC_ADDR_BITS = 48;

    // Memory command from the stack
    typedef struct packed {
        logic                 is_write;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
    } mem_cmd_t;

    // Memory status back to the stack
    typedef struct packed {
        logic       is_write;
        logic       ok;
        logic [5:0] tag;
    } mem_sts_t;

    // Which station address an update targets
    typedef enum logic [0:0] {
        CFG_IP  = 1'b0,
        CFG_MAC = 1'b1
    } cfg_kind_t;

    // IP view of the payload word, address in the low bits
    typedef struct packed {
        logic [MAC_ADDR_BITS-IP_ADDR_BITS-1:0] pad;
        logic [IP_ADDR_BITS-1:0]               ip;
    } cfg_ip_word_t;

    // One payload word, decoded by kind
    typedef union packed {
        logic [MAC_ADDR_BITS-1:0] mac;
        cfg_ip_word_t             ip_word;
    } cfg_payload_u;

    // Configuration update
    typedef struct packed {
        cfg_kind_t    kind;
        cfg_payload_u payload;
    } cfg_upd_t;

endpackage
